// ==== common/exec_pkg.sv ====
package exec_pkg;

    localparam int XLEN_DEFAULT = 32;

    // operand, result or address
    typedef logic [XLEN_DEFAULT-1:0] word_t;

    // destination register index
    typedef logic [4:0] reg_idx_t;

    // alu operation codes, shared with the decoder
    typedef logic [3:0] alu_ctrl_t;

    localparam alu_ctrl_t ALU_ADD  = 4'b0000;
    localparam alu_ctrl_t ALU_SUB  = 4'b0001;
    localparam alu_ctrl_t ALU_AND  = 4'b0010;
    localparam alu_ctrl_t ALU_OR   = 4'b0011;
    localparam alu_ctrl_t ALU_XOR  = 4'b0100;
    localparam alu_ctrl_t ALU_SLT  = 4'b0101;
    localparam alu_ctrl_t ALU_SLL  = 4'b0110;
    localparam alu_ctrl_t ALU_SLTU = 4'b0111;
    localparam alu_ctrl_t ALU_SRL  = 4'b1000;
    localparam alu_ctrl_t ALU_SRA  = 4'b1001;

    // forwarding select from the hazard unit
    // codes 011, 101 and 110 are unused and fall back to the register file
    typedef enum logic [2:0] {
        FWD_ALU_M    = 3'b000,
        FWD_RESULT_W = 3'b001,
        FWD_PC4_M    = 3'b010,
        FWD_IMM_M    = 3'b100,
        FWD_NONE     = 3'b111
    } fwd_sel_t;

    // writeback result source
    typedef logic [1:0] result_src_t;

    localparam result_src_t RES_ALU = 2'b00;
    localparam result_src_t RES_MEM = 2'b01;
    localparam result_src_t RES_PC4 = 2'b10;

endpackage

// ==== common/exec_if.sv ====
// registered decode fields, as seen in the execute stage
interface id_ex_if import exec_pkg::*; ();

    word_t       pc;
    word_t       pc_plus4;
    word_t       rd1;
    word_t       rd2;
    word_t       imm_ext;
    reg_idx_t    rd;

    alu_ctrl_t   alu_control;
    logic        alu_src;
    logic        src_a_pc;
    logic        branch;
    logic        jump;
    logic        funct3_0;
    logic        reg_write;
    logic        mem_write;
    logic        mem_read;
    result_src_t result_src;

    modport reg_side (
        output pc, pc_plus4, rd1, rd2, imm_ext, rd,
        output alu_control, alu_src, src_a_pc, branch, jump, funct3_0,
        output reg_write, mem_write, mem_read, result_src
    );

    modport stage_side (
        input pc, pc_plus4, rd1, rd2, imm_ext, rd,
        input alu_control, alu_src, src_a_pc, branch, jump, funct3_0,
        input reg_write, mem_write, mem_read, result_src
    );

endinterface

// alu operands in, result and flag out
interface alu_if import exec_pkg::*; ();

    word_t     a;
    word_t     b;
    alu_ctrl_t alu_control;
    word_t     result;
    logic      zero;

    modport src (output a, b, alu_control);

    modport alu (input a, b, alu_control, output result, zero);

    modport user (input result, zero);

endinterface

// ==== verilog/id_ex_reg.sv ====
module id_ex_reg import exec_pkg::*; #(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        flush,

    input  word_t       pc_d,
    input  word_t       pc_plus4_d,
    input  word_t       rd1_d,
    input  word_t       rd2_d,
    input  word_t       imm_ext_d,
    input  reg_idx_t    rd_d,

    input  alu_ctrl_t   alu_control_d,
    input  logic        alu_src_d,
    input  logic        src_a_pc_d,
    input  logic        branch_d,
    input  logic        jump_d,
    input  logic        funct3_0_d,
    input  logic        reg_write_d,
    input  logic        mem_write_d,
    input  logic        mem_read_d,
    input  result_src_t result_src_d,

    id_ex_if.reg_side   ex
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_plus4_q;
    logic [XLEN-1:0] rd1_q;
    logic [XLEN-1:0] rd2_q;
    logic [XLEN-1:0] imm_ext_q;
    reg_idx_t        rd_q;

    // payload follows the decode stage unless stalled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q       <= '0;
            pc_plus4_q <= '0;
            rd1_q      <= '0;
            rd2_q      <= '0;
            imm_ext_q  <= '0;
            rd_q       <= '0;
        end else if (flush || !stall) begin
            pc_q       <= pc_d;
            pc_plus4_q <= pc_plus4_d;
            rd1_q      <= rd1_d;
            rd2_q      <= rd2_d;
            imm_ext_q  <= imm_ext_d;
            rd_q       <= rd_d;
        end
    end

    // control fields, flush wins over stall and leaves a bubble
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            ex.alu_control <= ALU_ADD;
            ex.alu_src     <= 1'b0;
            ex.src_a_pc    <= 1'b0;
            ex.branch      <= 1'b0;
            ex.jump        <= 1'b0;
            ex.funct3_0    <= 1'b0;
            ex.reg_write   <= 1'b0;
            ex.mem_write   <= 1'b0;
            ex.mem_read    <= 1'b0;
            ex.result_src  <= '0;
        end else if (!stall) begin
            ex.alu_control <= alu_control_d;
            ex.alu_src     <= alu_src_d;
            ex.src_a_pc    <= src_a_pc_d;
            ex.branch      <= branch_d;
            ex.jump        <= jump_d;
            ex.funct3_0    <= funct3_0_d;
            ex.reg_write   <= reg_write_d;
            ex.mem_write   <= mem_write_d;
            ex.mem_read    <= mem_read_d;
            ex.result_src  <= result_src_d;
        end
    end

    assign ex.pc       = pc_q;
    assign ex.pc_plus4 = pc_plus4_q;
    assign ex.rd1      = rd1_q;
    assign ex.rd2      = rd2_q;
    assign ex.imm_ext  = imm_ext_q;
    assign ex.rd       = rd_q;

endmodule

// ==== verilog/operand_forward.sv ====
module operand_forward import exec_pkg::*; #(
    parameter int XLEN = XLEN_DEFAULT
) (
    id_ex_if.stage_side ex,

    // from hazard unit
    input  fwd_sel_t    forward_rd1,
    input  fwd_sel_t    forward_rd2,

    // later-stage values
    input  word_t       alu_result_m,
    input  word_t       result_w,
    input  word_t       pc_plus4_m,
    input  word_t       imm_ext_m,

    alu_if.src          alu_bus,
    output word_t       store_data
);

    logic [XLEN-1:0] rd1_fwd;
    logic [XLEN-1:0] rd2_fwd;

    // one forwarding mux, used for both sources
    function automatic logic [XLEN-1:0] fwd_pick(
        input fwd_sel_t        sel,
        input logic [XLEN-1:0] reg_val
    );
        logic [XLEN-1:0] val;
        case (sel)
            FWD_ALU_M:    val = alu_result_m;
            FWD_RESULT_W: val = result_w;
            FWD_PC4_M:    val = pc_plus4_m;
            FWD_IMM_M:    val = imm_ext_m;
            // FWD_NONE and the unused codes
            default:      val = reg_val;
        endcase
        return val;
    endfunction

    always_comb begin
        rd1_fwd = fwd_pick(forward_rd1, ex.rd1);
        rd2_fwd = fwd_pick(forward_rd2, ex.rd2);
    end

    // auipc and jal take pc as source a
    assign alu_bus.a = ex.src_a_pc ? ex.pc : rd1_fwd;

    // immediate forms, loads and stores use imm_ext
    assign alu_bus.b = ex.alu_src ? ex.imm_ext : rd2_fwd;

    assign alu_bus.alu_control = ex.alu_control;

    // store data always comes from the forwarded rs2
    assign store_data = rd2_fwd;

endmodule

// ==== verilog/alu.sv ====
module alu import exec_pkg::*; #(
    parameter int XLEN = XLEN_DEFAULT
) (
    alu_if.alu alu_bus
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0]  shamt;
    logic [XLEN-1:0] res;
    logic            lt_signed;
    logic            lt_unsigned;

    // rv32 shifts only look at the low bits of b
    assign shamt = alu_bus.b[SHW-1:0];

    assign lt_signed   = $signed(alu_bus.a) < $signed(alu_bus.b);
    assign lt_unsigned = alu_bus.a < alu_bus.b;

    always_comb begin
        case (alu_bus.alu_control)
            ALU_ADD:  res = alu_bus.a + alu_bus.b;
            ALU_SUB:  res = alu_bus.a - alu_bus.b;
            ALU_AND:  res = alu_bus.a & alu_bus.b;
            ALU_OR:   res = alu_bus.a | alu_bus.b;
            ALU_XOR:  res = alu_bus.a ^ alu_bus.b;
            ALU_SLT:  res = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLL:  res = alu_bus.a << shamt;
            ALU_SLTU: res = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_SRL:  res = alu_bus.a >> shamt;
            ALU_SRA:  res = $signed(alu_bus.a) >>> shamt;
            default:  res = '0;
        endcase
    end

    assign alu_bus.result = res;

    // used by beq and bne
    assign alu_bus.zero = (res == '0);

endmodule

// ==== verilog/branch_ctrl.sv ====
module branch_ctrl import exec_pkg::*; #(
    parameter int XLEN = XLEN_DEFAULT
) (
    id_ex_if.stage_side ex,
    alu_if.user         alu_bus,

    // to fetch and hazard unit
    output logic        pc_src,
    output word_t       pc_target,

    // to data memory
    output logic        data_memory_we,
    output logic        data_memory_re,

    // to memory stage
    output logic        reg_write_e,
    output result_src_t result_src_e,
    output reg_idx_t    rd_e,
    output word_t       pc_plus4_e
);

    logic            branch_met;
    logic [XLEN-1:0] branch_target;
    logic [XLEN-1:0] jump_target;

    // the decoder picks the compare op, funct3[0] flips it
    always_comb begin
        case (ex.alu_control)
            // beq, bne
            ALU_SUB:  branch_met = ex.funct3_0 ^ alu_bus.zero;
            // blt, bge
            ALU_SLT:  branch_met = ex.funct3_0 ^ alu_bus.result[0];
            // bltu, bgeu
            ALU_SLTU: branch_met = ex.funct3_0 ^ alu_bus.result[0];
            default:  branch_met = 1'b0;
        endcase
    end

    assign pc_src = (ex.branch & branch_met) | ex.jump;

    assign branch_target = ex.pc + ex.imm_ext;

    // jalr clears the low bit of the sum
    assign jump_target = {alu_bus.result[XLEN-1:1], 1'b0};

    assign pc_target = ex.jump ? jump_target : branch_target;

    assign data_memory_we = ex.mem_write;
    assign data_memory_re = ex.mem_read;

    // writeback controls travel on with the instruction
    assign reg_write_e  = ex.reg_write;
    assign result_src_e = ex.result_src;
    assign rd_e         = ex.rd;
    assign pc_plus4_e   = ex.pc_plus4;

endmodule

// ==== verilog/exec_stage.sv ====
module exec_stage import exec_pkg::*; #(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic        clk,
    input  logic        rst_n,

    // from decode
    input  word_t       pc_d,
    input  word_t       pc_plus4_d,
    input  word_t       rd1_d,
    input  word_t       rd2_d,
    input  word_t       imm_ext_d,
    input  reg_idx_t    rd_d,
    input  alu_ctrl_t   alu_control_d,
    input  logic        alu_src_d,
    input  logic        src_a_pc_d,
    input  logic        branch_d,
    input  logic        jump_d,
    input  logic        funct3_0_d,
    input  logic        reg_write_d,
    input  logic        mem_write_d,
    input  logic        mem_read_d,
    input  result_src_t result_src_d,

    // from hazard unit
    input  logic        stall_e,
    input  logic        flush_e,
    input  fwd_sel_t    forward_rd1_e,
    input  fwd_sel_t    forward_rd2_e,

    // from memory and writeback stages
    input  word_t       alu_result_m,
    input  word_t       result_w,
    input  word_t       pc_plus4_m,
    input  word_t       imm_ext_m,

    // to data memory
    output word_t       alu_result_e,
    output word_t       data_addr,
    output word_t       data_to_memory,
    output logic        data_memory_we,
    output logic        data_memory_re,

    // to fetch and hazard unit
    output word_t       pc_target_e,
    output logic        pc_src_e,

    // to memory stage
    output reg_idx_t    rd_e,
    output logic        reg_write_e,
    output result_src_t result_src_e,
    output word_t       pc_plus4_e
);

    id_ex_if ex_bus ();
    alu_if   alu_bus ();

    id_ex_reg #(
        .XLEN (XLEN)
    ) u_id_ex_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall_e),
        .flush         (flush_e),
        .pc_d          (pc_d),
        .pc_plus4_d    (pc_plus4_d),
        .rd1_d         (rd1_d),
        .rd2_d         (rd2_d),
        .imm_ext_d     (imm_ext_d),
        .rd_d          (rd_d),
        .alu_control_d (alu_control_d),
        .alu_src_d     (alu_src_d),
        .src_a_pc_d    (src_a_pc_d),
        .branch_d      (branch_d),
        .jump_d        (jump_d),
        .funct3_0_d    (funct3_0_d),
        .reg_write_d   (reg_write_d),
        .mem_write_d   (mem_write_d),
        .mem_read_d    (mem_read_d),
        .result_src_d  (result_src_d),
        .ex            (ex_bus)
    );

    operand_forward #(
        .XLEN (XLEN)
    ) u_operand_forward (
        .ex           (ex_bus),
        .forward_rd1  (forward_rd1_e),
        .forward_rd2  (forward_rd2_e),
        .alu_result_m (alu_result_m),
        .result_w     (result_w),
        .pc_plus4_m   (pc_plus4_m),
        .imm_ext_m    (imm_ext_m),
        .alu_bus      (alu_bus),
        .store_data   (data_to_memory)
    );

    alu #(
        .XLEN (XLEN)
    ) u_alu (
        .alu_bus (alu_bus)
    );

    branch_ctrl #(
        .XLEN (XLEN)
    ) u_branch_ctrl (
        .ex             (ex_bus),
        .alu_bus        (alu_bus),
        .pc_src         (pc_src_e),
        .pc_target      (pc_target_e),
        .data_memory_we (data_memory_we),
        .data_memory_re (data_memory_re),
        .reg_write_e    (reg_write_e),
        .result_src_e   (result_src_e),
        .rd_e           (rd_e),
        .pc_plus4_e     (pc_plus4_e)
    );

    // loads and stores address through the alu
    assign alu_result_e = alu_bus.result;
    assign data_addr    = alu_bus.result;

endmodule

// ==== verification/exec_stage_assert.sv ====
module exec_stage_assert (
    input logic clk,
    input logic rst_n,
    input logic stall_e,
    input logic flush_e,
    input logic branch_d,
    input logic jump_d,
    input logic pc_src_e,
    input logic data_memory_we,
    input logic data_memory_re
);

    // a redirect needs a branch or a jump decoded into this slot
    taken_needs_control: assert property (
        @(posedge clk) disable iff (!rst_n)
        pc_src_e |-> ($past(stall_e && !flush_e) || $past(branch_d || jump_d))
    ) else $error("pc_src_e high without branch or jump in execute");

    strobes_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(data_memory_we && data_memory_re)
    ) else $error("data memory write and read strobes both high");

    // flushed slot is a bubble in the following cycle
    flush_gives_bubble: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush_e |=> (!data_memory_we && !data_memory_re && !pc_src_e)
    ) else $error("strobes not low in the cycle after a flush");

endmodule

bind exec_stage exec_stage_assert u_exec_stage_assert (
    .clk            (clk),
    .rst_n          (rst_n),
    .stall_e        (stall_e),
    .flush_e        (flush_e),
    .branch_d       (branch_d),
    .jump_d         (jump_d),
    .pc_src_e       (pc_src_e),
    .data_memory_we (data_memory_we),
    .data_memory_re (data_memory_re)
);

// ==== verification/exec_stage_tb.sv ====
module exec_stage_tb import exec_pkg::*; ();

    localparam int PERIOD = 100;
    localparam int N_RESET = 3;
    localparam int N_ALU = 40;
    localparam int N_FWD = 64;
    localparam int N_BR = 56;
    localparam int N_MEM = 16;
    localparam int N_HOLD = 32;
    localparam int TOTAL_CYCLES = 8 + N_RESET + N_ALU + N_FWD + N_BR + N_MEM + N_HOLD + 2;
    localparam int MARGIN = 20;

    typedef struct packed {
        word_t       pc;
        word_t       pc_plus4;
        word_t       rd1;
        word_t       rd2;
        word_t       imm_ext;
        reg_idx_t    rd;
        alu_ctrl_t   alu_control;
        logic        alu_src;
        logic        src_a_pc;
        logic        branch;
        logic        jump;
        logic        funct3_0;
        logic        reg_write;
        logic        mem_write;
        logic        mem_read;
        result_src_t result_src;
    } instr_t;

    typedef struct packed {
        word_t       alu_result;
        word_t       data_to_memory;
        word_t       pc_target;
        logic        pc_src;
        logic        we;
        logic        re;
        logic        reg_write;
        result_src_t result_src;
        reg_idx_t    rd;
        word_t       pc_plus4;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        drv_stall;
    logic        drv_flush;
    instr_t      drv_instr;
    instr_t      reg_model;
    fwd_sel_t    sel1;
    fwd_sel_t    sel2;
    word_t       alu_m;
    word_t       res_w;
    word_t       pc4_m;
    word_t       imm_m;
    integer      seed = 32'h76f6_6917;
    int          err_count = 0;
    logic        check_en = 1'b0;
    string       test_name = "idle";

    word_t       alu_result_e;
    word_t       data_addr;
    word_t       data_to_memory;
    logic        data_memory_we;
    logic        data_memory_re;
    word_t       pc_target_e;
    logic        pc_src_e;
    reg_idx_t    rd_e;
    logic        reg_write_e;
    result_src_t result_src_e;
    word_t       pc_plus4_e;

    exec_stage #(
        .XLEN (XLEN_DEFAULT)
    ) UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .pc_d           (drv_instr.pc),
        .pc_plus4_d     (drv_instr.pc_plus4),
        .rd1_d          (drv_instr.rd1),
        .rd2_d          (drv_instr.rd2),
        .imm_ext_d      (drv_instr.imm_ext),
        .rd_d           (drv_instr.rd),
        .alu_control_d  (drv_instr.alu_control),
        .alu_src_d      (drv_instr.alu_src),
        .src_a_pc_d     (drv_instr.src_a_pc),
        .branch_d       (drv_instr.branch),
        .jump_d         (drv_instr.jump),
        .funct3_0_d     (drv_instr.funct3_0),
        .reg_write_d    (drv_instr.reg_write),
        .mem_write_d    (drv_instr.mem_write),
        .mem_read_d     (drv_instr.mem_read),
        .result_src_d   (drv_instr.result_src),
        .stall_e        (drv_stall),
        .flush_e        (drv_flush),
        .forward_rd1_e  (sel1),
        .forward_rd2_e  (sel2),
        .alu_result_m   (alu_m),
        .result_w       (res_w),
        .pc_plus4_m     (pc4_m),
        .imm_ext_m      (imm_m),
        .alu_result_e   (alu_result_e),
        .data_addr      (data_addr),
        .data_to_memory (data_to_memory),
        .data_memory_we (data_memory_we),
        .data_memory_re (data_memory_re),
        .pc_target_e    (pc_target_e),
        .pc_src_e       (pc_src_e),
        .rd_e           (rd_e),
        .reg_write_e    (reg_write_e),
        .result_src_e   (result_src_e),
        .pc_plus4_e     (pc_plus4_e)
    );

    always #(PERIOD/2) clk = ~clk;

    function automatic word_t pick_source(input fwd_sel_t sel, input word_t reg_val,
                                          input word_t am, input word_t rw,
                                          input word_t p4, input word_t im);
        if (sel == FWD_ALU_M) return am;
        if (sel == FWD_RESULT_W) return rw;
        if (sel == FWD_PC4_M) return p4;
        if (sel == FWD_IMM_M) return im;
        return reg_val;
    endfunction

    // expected execute outputs for the instruction held in the register
    function automatic expect_t exec_model(input instr_t i, input fwd_sel_t s1,
                                           input fwd_sel_t s2, input word_t am,
                                           input word_t rw, input word_t p4,
                                           input word_t im);
        expect_t e;
        word_t   r1;
        word_t   r2;
        word_t   a;
        word_t   b;
        word_t   res;
        logic    cond;
        r1 = pick_source(s1, i.rd1, am, rw, p4, im);
        r2 = pick_source(s2, i.rd2, am, rw, p4, im);
        a = i.src_a_pc ? i.pc : r1;
        b = i.alu_src ? i.imm_ext : r2;
        case (i.alu_control)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a + ~b + 32'd1;
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_SLT:  res = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
            ALU_SLTU: res = {31'b0, a < b};
            ALU_SLL:  res = a << b[4:0];
            ALU_SRL:  res = a >> b[4:0];
            ALU_SRA:  res = (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
            default:  res = '0;
        endcase
        // only the compare ops can take a branch
        if (i.alu_control == ALU_SUB) cond = (res == 32'h0) ^ i.funct3_0;
        else if (i.alu_control == ALU_SLT || i.alu_control == ALU_SLTU) cond = res[0] ^ i.funct3_0;
        else cond = 1'b0;
        e.alu_result = res;
        e.data_to_memory = r2;
        e.pc_target = i.jump ? {res[31:1], 1'b0} : i.pc + i.imm_ext;
        e.pc_src = (i.branch && cond) || i.jump;
        e.we = i.mem_write;
        e.re = i.mem_read;
        e.reg_write = i.reg_write;
        e.result_src = i.result_src;
        e.rd = i.rd;
        e.pc_plus4 = i.pc_plus4;
        return e;
    endfunction

    function automatic instr_t bubble_of(input instr_t i);
        instr_t b;
        b = i;
        b.alu_control = ALU_ADD;
        b.alu_src = 1'b0;
        b.src_a_pc = 1'b0;
        b.branch = 1'b0;
        b.jump = 1'b0;
        b.funct3_0 = 1'b0;
        b.reg_write = 1'b0;
        b.mem_write = 1'b0;
        b.mem_read = 1'b0;
        b.result_src = RES_ALU;
        return b;
    endfunction

    task automatic report_mismatch(input string sig, input string exp_s, input string act_s);
        err_count++;
        $display("ERROR %s %s: expected %s, actual %s", test_name, sig, exp_s, act_s);
        $display("Test failures found");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_word(input string sig, input word_t exp_v, input word_t act_v);
        if (act_v !== exp_v) report_mismatch(sig, $sformatf("%h", exp_v), $sformatf("%h", act_v));
    endtask

    task automatic check_bit(input string sig, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) report_mismatch(sig, $sformatf("%b", exp_v), $sformatf("%b", act_v));
    endtask

    task automatic check_reg(input string sig, input reg_idx_t exp_v, input reg_idx_t act_v);
        if (act_v !== exp_v) report_mismatch(sig, $sformatf("%0d", exp_v), $sformatf("%0d", act_v));
    endtask

    task automatic check_result_src(input string sig, input result_src_t exp_v,
                                    input result_src_t act_v);
        if (act_v !== exp_v) report_mismatch(sig, $sformatf("%b", exp_v), $sformatf("%b", act_v));
    endtask

    // mirror of the pipeline register, updated from the driven levels
    always @(posedge clk) begin
        if (!rst_n) begin
            reg_model = '0;
        end else if (drv_flush) begin
            reg_model = bubble_of(drv_instr);
        end else if (!drv_stall) begin
            reg_model = drv_instr;
        end
    end

    // compare a quarter period before each rising edge
    always @(negedge clk) begin
        expect_t e;
        #(PERIOD/4);
        if (check_en) begin
            e = exec_model(reg_model, sel1, sel2, alu_m, res_w, pc4_m, imm_m);
            check_word("alu_result_e", e.alu_result, alu_result_e);
            check_word("data_addr", e.alu_result, data_addr);
            check_word("data_to_memory", e.data_to_memory, data_to_memory);
            check_word("pc_target_e", e.pc_target, pc_target_e);
            check_word("pc_plus4_e", e.pc_plus4, pc_plus4_e);
            check_bit("pc_src_e", e.pc_src, pc_src_e);
            check_bit("data_memory_we", e.we, data_memory_we);
            check_bit("data_memory_re", e.re, data_memory_re);
            check_bit("reg_write_e", e.reg_write, reg_write_e);
            check_reg("rd_e", e.rd, rd_e);
            check_result_src("result_src_e", e.result_src, result_src_e);
        end
    end

    task automatic step(input instr_t d, input fwd_sel_t s1, input fwd_sel_t s2,
                        input logic stall, input logic flush, input string name);
        @(negedge clk);
        drv_instr = d;
        sel1 = s1;
        sel2 = s2;
        drv_stall = stall;
        drv_flush = flush;
        alu_m = $random(seed);
        res_w = $random(seed);
        pc4_m = $random(seed);
        imm_m = $random(seed);
        test_name = name;
    endtask

    task automatic rand_alu_instr(output instr_t i);
        logic [31:0] r;
        i = '0;
        i.pc = $random(seed);
        i.pc_plus4 = i.pc + 32'd4;
        i.rd1 = $random(seed);
        i.rd2 = $random(seed);
        i.imm_ext = $random(seed);
        r = $random(seed);
        i.rd = r[4:0];
        i.alu_control = (r[11:8] > 4'd9) ? r[11:8] - 4'd6 : r[11:8];
        i.alu_src = r[12];
        i.src_a_pc = r[13];
        i.reg_write = 1'b1;
        i.result_src = RES_ALU;
    endtask

    initial begin
        #((TOTAL_CYCLES + MARGIN) * PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Test failures found");
        $fatal(1, "timeout");
    end

    initial begin
        instr_t ins;
        // decode keeps presenting a live jump with a load while reset is held
        rand_alu_instr(ins);
        ins.jump = 1'b1;
        ins.mem_read = 1'b1;
        rst_n = 1'b0;
        drv_instr = ins;
        drv_stall = 1'b0;
        drv_flush = 1'b0;
        sel1 = FWD_NONE;
        sel2 = FWD_NONE;
        alu_m = '0;
        res_w = '0;
        pc4_m = '0;
        imm_m = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        drv_instr = '0;
        test_name = "reset";
        check_en = 1'b1;
        repeat (N_RESET) step('0, FWD_NONE, FWD_NONE, 1'b0, 1'b0, "reset");
        for (int k = 0; k < N_ALU; k++) begin
            rand_alu_instr(ins);
            step(ins, FWD_NONE, FWD_NONE, 1'b0, 1'b0, "alu random");
        end
        // selects act on the instruction issued one step earlier
        for (int k = 0; k < N_FWD; k++) begin
            rand_alu_instr(ins);
            ins.alu_src = 1'b0;
            ins.src_a_pc = 1'b0;
            step(ins, fwd_sel_t'(k[2:0]), fwd_sel_t'(k[5:3]), 1'b0, 1'b0, "forward");
        end
        for (int k = 0; k < N_BR; k++) begin
            rand_alu_instr(ins);
            ins.alu_src = 1'b0;
            ins.src_a_pc = 1'b0;
            ins.reg_write = 1'b0;
            ins.branch = 1'b1;
            ins.funct3_0 = k[3];
            case (k[1:0])
                2'd0:    ins.alu_control = ALU_SUB;
                2'd1:    ins.alu_control = ALU_SLT;
                2'd2:    ins.alu_control = ALU_SLTU;
                default: ins.alu_control = ALU_ADD;
            endcase
            if (k[2]) ins.rd2 = ins.rd1;
            if (k >= N_BR - 8) begin
                // jal when pc is source a, jalr otherwise
                ins.branch = 1'b0;
                ins.jump = 1'b1;
                ins.alu_src = 1'b1;
                ins.src_a_pc = k[0];
                ins.alu_control = ALU_ADD;
                ins.reg_write = 1'b1;
                ins.result_src = RES_PC4;
            end
            step(ins, FWD_NONE, FWD_NONE, 1'b0, 1'b0, ins.jump ? "jump" : "branch");
        end
        for (int k = 0; k < N_MEM; k++) begin
            rand_alu_instr(ins);
            ins.alu_control = ALU_ADD;
            ins.alu_src = 1'b1;
            ins.src_a_pc = 1'b0;
            ins.mem_write = k[0];
            ins.mem_read = !k[0];
            ins.reg_write = !k[0];
            ins.result_src = k[0] ? RES_ALU : RES_MEM;
            step(ins, fwd_sel_t'(k[2:0]), fwd_sel_t'(k[3:1]), 1'b0, 1'b0, "load store");
        end
        for (int k = 0; k < N_HOLD / 8; k++) begin
            rand_alu_instr(ins);
            ins.mem_read = 1'b1;
            step(ins, FWD_NONE, FWD_NONE, 1'b0, 1'b0, "stall load");
            repeat (3) begin
                rand_alu_instr(ins);
                step(ins, FWD_NONE, FWD_NONE, 1'b1, 1'b0, "stall hold");
            end
            rand_alu_instr(ins);
            ins.mem_write = 1'b1;
            step(ins, FWD_NONE, FWD_NONE, 1'b0, 1'b1, "flush");
            rand_alu_instr(ins);
            step(ins, FWD_NONE, FWD_NONE, 1'b1, 1'b1, "flush over stall");
            rand_alu_instr(ins);
            step(ins, FWD_NONE, FWD_NONE, 1'b0, 1'b0, "after flush");
            step(ins, FWD_NONE, FWD_NONE, 1'b0, 1'b0, "after flush");
        end
        step('0, FWD_NONE, FWD_NONE, 1'b0, 1'b0, "drain");
        @(posedge clk);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== exec_stage.f ====
common/exec_pkg.sv
common/exec_if.sv
verilog/id_ex_reg.sv
verilog/operand_forward.sv
verilog/alu.sv
verilog/branch_ctrl.sv
verilog/exec_stage.sv
verification/exec_stage_assert.sv
verification/exec_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module exec_stage_tb \
    -f exec_stage.f -o exec_stage_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/exec_stage_sim > sim.log 2>&1
cat sim.log

grep -q "Test failures found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "All tests passed!" sim.log && exit 0 || { echo "simulation did not finish"; exit 1; }
